// File: Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - hdl/mem_pkg.sv
      - hdl/mem_region_decode.sv
      - hdl/byte_ram.sv
      - hdl/uart_port.sv
      - hdl/load_extend.sv
      - hdl/mem_subsys_top.sv
  - target: test
    files:
      - testbench/mem_subsys_asserts.sv
      - testbench/mem_subsys_tb.sv

// File: hdl/byte_ram.sv
/*
 * Word-wide synchronous RAM, byte-enabled write port
 * and an independent registered read port
 */

`timescale 1ns/1ps
`default_nettype none

module byte_ram #(
    parameter int depth = mem_pkg::ram_words
) (
    input  logic                               clk,
    input  mem_pkg::wr_port_t                  wr,
    input  logic                               wr_en,
    input  logic [mem_pkg::ram_addr_bits-1:0]  rd_addr,
    output logic [31:0]                        rd_data
);

    logic [31:0] mem [depth];

    // ------------------------------
    // Write port
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            for (int lane = 0; lane < 4; lane++)
            begin
                if (wr.be[lane])
                begin
                    mem[wr.idx][8*lane +: 8] <= wr.data[8*lane +: 8];
                end
            end
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------
    // Same-word read during a write sees the old contents
    always_ff @(posedge clk)
    begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/load_extend.sv
/*
 * Load return path: registers the load attributes at accept,
 * then aligns and extends the selected word one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

module load_extend (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               load_accept,
    input  mem_pkg::region_t   region,
    input  logic [2:0]         funct3,
    input  logic [1:0]         offset,
    input  logic [31:0]        dmem_word,
    input  logic [31:0]        uart_word,
    output logic               rsp_valid,
    output mem_pkg::mem_rsp_t  rsp
);

    typedef enum logic [1:0] {
        src_zero,
        src_dmem,
        src_uart
    } src_e;

    typedef struct packed {
        src_e       src;
        logic [2:0] funct3;
        logic [1:0] offset;
    } ld_ctx_t;

    ld_ctx_t     ctx;
    logic [31:0] uart_q;
    logic [31:0] word;
    logic [31:0] shifted;

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= load_accept;
        end
    end

    // Attributes and the UART word are captured together at accept
    always_ff @(posedge clk)
    begin
        if (load_accept)
        begin
            if (region.dmem)
            begin
                ctx.src <= src_dmem;
            end
            else if (region.uart_rx_pop || region.uart_status)
            begin
                ctx.src <= src_uart;
            end
            else
            begin
                ctx.src <= src_zero;
            end
            ctx.funct3 <= funct3;
            ctx.offset <= offset;
            uart_q     <= uart_word;
        end
    end

    // ------------------------------
    // Align and extend
    // ------------------------------
    always_comb
    begin
        case (ctx.src)
            src_dmem: word = dmem_word;
            src_uart: word = uart_q;
            default:  word = 32'h0;
        endcase

        shifted = word >> {ctx.offset, 3'b000};

        case (ctx.funct3)
            mem_pkg::fnc_b:  rsp.data = {{24{shifted[7]}}, shifted[7:0]};
            mem_pkg::fnc_bu: rsp.data = {24'h0, shifted[7:0]};
            mem_pkg::fnc_h:  rsp.data = {{16{shifted[15]}}, shifted[15:0]};
            mem_pkg::fnc_hu: rsp.data = {16'h0, shifted[15:0]};
            default:         rsp.data = shifted;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mem_pkg.sv
/*
 * Shared definitions for the data-side memory subsystem:
 * opcode and funct3 codes, memory sizes, request, response and write-port structs
 */

`default_nettype none

package mem_pkg;

    // ------------------------------
    // Memory geometry
    // ------------------------------
    localparam int ram_words     = 1024;
    localparam int ram_addr_bits = 10;

    // UART lives in the 0x8xxx_xxxx region
    localparam logic [3:0] uart_base      = 4'h8;
    localparam logic [2:0] uart_rx_offset = 3'h4;

    // ------------------------------
    // RISC-V encodings
    // ------------------------------
    localparam logic [6:0] opc_load  = 7'b000_0011;
    localparam logic [6:0] opc_store = 7'b010_0011;

    localparam logic [2:0] fnc_b  = 3'b000;
    localparam logic [2:0] fnc_h  = 3'b001;
    localparam logic [2:0] fnc_w  = 3'b010;
    localparam logic [2:0] fnc_bu = 3'b100;
    localparam logic [2:0] fnc_hu = 3'b101;

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_load  = 2'd1,
        op_store = 2'd2
    } mem_op_e;

    // ------------------------------
    // Channel payloads
    // ------------------------------
    typedef struct packed {
        logic [6:0]  opcode;
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] data;
    } mem_rsp_t;

    // One word write, shared by both memories
    typedef struct packed {
        logic [ram_addr_bits-1:0] idx;
        logic [3:0]               be;
        logic [31:0]              data;
    } wr_port_t;

    typedef struct packed {
        logic dmem;
        logic imem;
        logic uart_tx;
        logic uart_rx_pop;
        logic uart_status;
    } region_t;

endpackage

`default_nettype wire

// File: hdl/mem_region_decode.sv
/*
 * Address and opcode decode: region selects, store byte enables
 * and lane-aligned store data
 */

`timescale 1ns/1ps
`default_nettype none

module mem_region_decode (
    input  mem_pkg::mem_req_t  req,
    input  logic               accept,
    output mem_pkg::region_t   region,
    output mem_pkg::wr_port_t  wr
);

    mem_pkg::mem_op_e op;
    logic [3:0]       mask;
    logic [1:0]       offset;
    logic             in_uart;

    assign offset = req.addr[1:0];

    // ------------------------------
    // Opcode class and size mask
    // ------------------------------
    always_comb
    begin
        case (req.opcode)
            mem_pkg::opc_load:  op = mem_pkg::op_load;
            mem_pkg::opc_store: op = mem_pkg::op_store;
            default:            op = mem_pkg::op_none;
        endcase
    end

    always_comb
    begin
        case (req.funct3)
            mem_pkg::fnc_b,
            mem_pkg::fnc_bu: mask = 4'b0001;
            mem_pkg::fnc_h,
            mem_pkg::fnc_hu: mask = 4'b0011;
            default:         mask = 4'b1111;
        endcase
    end

    // ------------------------------
    // Region selects
    // ------------------------------
    assign in_uart = (req.addr[31:28] == mem_pkg::uart_base);

    always_comb
    begin
        // Data and instruction regions may overlap, a store then hits both
        region.dmem = !req.addr[31] && req.addr[28];
        region.imem = !req.addr[31] && req.addr[29];

        region.uart_tx     = (op == mem_pkg::op_store) && in_uart;
        region.uart_rx_pop = (op == mem_pkg::op_load) && in_uart
                             && (req.addr[2:0] == mem_pkg::uart_rx_offset);
        region.uart_status = (op == mem_pkg::op_load) && in_uart
                             && (req.addr[2:0] == 3'h0);
    end

    // ------------------------------
    // Write port
    // ------------------------------
    always_comb
    begin
        wr.idx = req.addr[mem_pkg::ram_addr_bits+1:2];

        // Lanes shifted past bit 3 fall off, so a crossing store loses its top bytes
        if (op == mem_pkg::op_store && accept)
        begin
            wr.be = mask << offset;
        end
        else
        begin
            wr.be = 4'b0000;
        end

        wr.data = req.data << {offset, 3'b000};
    end

endmodule

`default_nettype wire

// File: hdl/mem_subsys_top.sv
/*
 * Data-side memory subsystem top: request handshake, region decode,
 * data and instruction memories, UART port and load return path
 */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
    input  logic                               clk,
    input  logic                               arst_n,

    // Request and response
    input  logic                               req_valid,
    input  mem_pkg::mem_req_t                  req,
    output logic                               req_ready,
    output logic                               rsp_valid,
    output mem_pkg::mem_rsp_t                  rsp,

    // Instruction fetch
    input  logic [mem_pkg::ram_addr_bits-1:0]  imem_addr,
    output logic [31:0]                        imem_data,

    // UART byte channels
    output logic                               tx_valid,
    output logic [7:0]                         tx_data,
    input  logic                               tx_ready,
    input  logic                               rx_valid,
    input  logic [7:0]                         rx_data,
    output logic                               rx_ready
);

    mem_pkg::mem_op_e  op;
    mem_pkg::region_t  region;
    mem_pkg::wr_port_t wr;
    logic              accept;
    logic              load_accept;
    logic              tx_full;
    logic [31:0]       dmem_word;
    logic [31:0]       uart_status;
    logic [31:0]       uart_rx_word;

    assign op = (req.opcode == mem_pkg::opc_load)  ? mem_pkg::op_load  :
                (req.opcode == mem_pkg::opc_store) ? mem_pkg::op_store :
                                                     mem_pkg::op_none;

    // ------------------------------
    // Handshake
    // ------------------------------
    // Only a transmit store into a full buffer stalls
    assign req_ready   = !(region.uart_tx && tx_full);
    assign accept      = req_valid && req_ready;
    assign load_accept = accept && (op == mem_pkg::op_load);

    mem_region_decode decode_i (
        .req    (req),
        .accept (accept),
        .region (region),
        .wr     (wr)
    );

    byte_ram dmem_i (
        .clk     (clk),
        .wr      (wr),
        .wr_en   (region.dmem),
        .rd_addr (req.addr[mem_pkg::ram_addr_bits+1:2]),
        .rd_data (dmem_word)
    );

    byte_ram imem_i (
        .clk     (clk),
        .wr      (wr),
        .wr_en   (region.imem),
        .rd_addr (imem_addr),
        .rd_data (imem_data)
    );

    uart_port uart_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (region.uart_tx && accept),
        .push_data (req.data[7:0]),
        .pop       (region.uart_rx_pop && accept),
        .status    (uart_status),
        .rx_word   (uart_rx_word),
        .tx_full   (tx_full),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready)
    );

    load_extend load_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .load_accept (load_accept),
        .region      (region),
        .funct3      (req.funct3),
        .offset      (req.addr[1:0]),
        .dmem_word   (dmem_word),
        .uart_word   (region.uart_rx_pop ? uart_rx_word : uart_status),
        .rsp_valid   (rsp_valid),
        .rsp         (rsp)
    );

endmodule

`default_nettype wire

// File: hdl/uart_port.sv
/*
 * UART side of the subsystem: one-byte transmit and receive buffers,
 * valid/ready byte channels and the status word
 */

`timescale 1ns/1ps
`default_nettype none

module uart_port (
    input  logic        clk,
    input  logic        arst_n,

    // Core side
    input  logic        push,
    input  logic [7:0]  push_data,
    input  logic        pop,
    output logic [31:0] status,
    output logic [31:0] rx_word,
    output logic        tx_full,

    // Byte channels
    output logic        tx_valid,
    output logic [7:0]  tx_data,
    input  logic        tx_ready,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    output logic        rx_ready
);

    logic [7:0] tx_buf;
    logic [7:0] rx_buf;
    logic       rx_full;

    // ------------------------------
    // Transmit buffer
    // ------------------------------
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tx_full <= 1'b0;
        end
        else if (push)
        begin
            tx_full <= 1'b1;
        end
        else if (tx_valid && tx_ready)
        begin
            tx_full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            tx_buf <= push_data;
        end
    end

    assign tx_valid = tx_full;
    assign tx_data  = tx_buf;

    // ------------------------------
    // Receive buffer
    // ------------------------------
    // A fill wins, pop on an empty buffer does nothing
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rx_full <= 1'b0;
        end
        else if (rx_valid && rx_ready)
        begin
            rx_full <= 1'b1;
        end
        else if (pop)
        begin
            rx_full <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_valid && rx_ready)
        begin
            rx_buf <= rx_data;
        end
    end

    assign rx_ready = !rx_full;
    assign rx_word  = rx_full ? {24'h0, rx_buf} : 32'h0;

    // Bit 0 tx empty, bit 1 rx holds a byte
    assign status = {30'h0, rx_full, !tx_full};

endmodule

`default_nettype wire

// File: src.f
hdl/mem_pkg.sv
hdl/mem_region_decode.sv
hdl/byte_ram.sv
hdl/uart_port.sv
hdl/load_extend.sv
hdl/mem_subsys_top.sv
testbench/mem_subsys_asserts.sv
testbench/mem_subsys_tb.sv

// File: testbench/mem_subsys_asserts.sv
/*
 * Handshake, timing and reset assertions,
 * bound into the memory subsystem top level
 */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_asserts (
    input logic               clk,
    input logic               arst_n,
    input logic               req_valid,
    input mem_pkg::mem_req_t  req,
    input logic               req_ready,
    input mem_pkg::wr_port_t  wr,
    input logic               rsp_valid,
    input logic               tx_valid,
    input logic [7:0]         tx_data,
    input logic               tx_ready,
    input logic               rx_ready
);

    // Number of failed assertions
    int   fail_count = 0;
    logic load_taken;

    // Load seen on the request channel at an accepting edge
    assign load_taken = req_valid && req_ready && (req.opcode == mem_pkg::opc_load);

    // ------------------------------
    // Load response timing
    // ------------------------------
    rsp_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        load_taken |=> rsp_valid)
    else
    begin
        $error("rsp_valid missing one cycle after an accepted load");
        fail_count++;
    end

    rsp_only_after_load: assert property (@(posedge clk) disable iff (!arst_n)
        !load_taken |=> !rsp_valid)
    else
    begin
        $error("rsp_valid raised without an accepted load");
        fail_count++;
    end

    // ------------------------------
    // Channel stability
    // ------------------------------
    tx_held: assert property (@(posedge clk) disable iff (!arst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data))
    else
    begin
        $error("tx_valid or tx_data changed before tx_ready");
        fail_count++;
    end

    req_held: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
    else
    begin
        $error("Request changed while stalled");
        fail_count++;
    end

    reset_idle: assert property (@(posedge clk)
        !arst_n |-> !rsp_valid && !tx_valid && rx_ready && wr.be == 4'b0000)
    else
    begin
        $error("Outputs active during reset");
        fail_count++;
    end

endmodule

bind mem_subsys_top mem_subsys_asserts asserts_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .wr          (wr),
    .rsp_valid   (rsp_valid),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_ready    (tx_ready),
    .rx_ready    (rx_ready)
);

`default_nettype wire

// File: testbench/mem_subsys_tb.sv
/*
 * Testbench for the memory subsystem: clock, reset, LFSR stimulus,
 * byte-array memory models, response and tx monitors, timeout
 */

`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;

    // Roughly 170, 50, 35, 25, 40 and 80 cycles for tests 1 to 6
    localparam int test_cycles    = 400;
    localparam int timeout_cycles = test_cycles * 2 + 200;

    localparam logic [31:0] dmem_base = 32'h1000_0000;
    localparam logic [31:0] imem_base = 32'h2000_0000;
    localparam logic [31:0] both_base = 32'h3000_0000;
    localparam logic [31:0] uart_stat = 32'h8000_0000;
    localparam logic [31:0] uart_rx   = 32'h8000_0004;

    logic                              clk;
    logic                              arst_n;
    logic                              req_valid;
    mem_pkg::mem_req_t                 req;
    logic                              req_ready;
    logic                              rsp_valid;
    mem_pkg::mem_rsp_t                 rsp;
    logic [mem_pkg::ram_addr_bits-1:0] imem_addr;
    logic [31:0]                       imem_data;
    logic                              tx_valid;
    logic [7:0]                        tx_data;
    logic                              tx_ready;
    logic                              rx_valid;
    logic [7:0]                        rx_data;
    logic                              rx_ready;

    // Byte models of both memories and the expected channel contents
    logic [7:0]  dmem_m [4096];
    logic [7:0]  imem_m [4096];
    logic [31:0] rsp_exp [$];
    logic [7:0]  tx_exp [$];
    logic [7:0]  rx_exp [$];
    logic [9:0]  dmem_words [$];
    logic [9:0]  imem_words [$];

    logic [31:0] lfsr = 32'hce7c;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;
    int          checks_mark = 0;
    int          errors_mark = 0;
    int          stall_cycles;
    int          assert_fails;

    mem_subsys_top dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .tx_valid  (tx_valid),
        .tx_data   (tx_data),
        .tx_ready  (tx_ready),
        .rx_valid  (rx_valid),
        .rx_data   (rx_data),
        .rx_ready  (rx_ready)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= timeout_cycles)
        begin
            $display("Timeout: run exceeded %0d cycles", timeout_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------
    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] want);
        checks++;
        if (got !== want)
        begin
            errors++;
            $display("MISMATCH %s: got %h, expected %h", name, got, want);
        end
    endtask

    function automatic logic [31:0] extend(input logic [2:0] f3, input logic [31:0] v);
        case (f3)
            mem_pkg::fnc_b:  return {{24{v[7]}}, v[7:0]};
            mem_pkg::fnc_bu: return {24'h0, v[7:0]};
            mem_pkg::fnc_h:  return {{16{v[15]}}, v[15:0]};
            mem_pkg::fnc_hu: return {16'h0, v[15:0]};
            default:         return v;
        endcase
    endfunction

    function automatic void model_store(input logic [2:0] f3, input logic [31:0] addr,
                                        input logic [31:0] data);
        int          n;
        logic [11:0] a;
        case (f3)
            mem_pkg::fnc_b, mem_pkg::fnc_bu: n = 1;
            mem_pkg::fnc_h, mem_pkg::fnc_hu: n = 2;
            default:                         n = 4;
        endcase
        // Bytes past the end of the word are dropped
        for (int k = 0; k < n; k++)
        begin
            if (int'(addr[1:0]) + k < 4)
            begin
                a = addr[11:0] + 12'(k);
                if (!addr[31] && addr[28])
                begin
                    dmem_m[a] = data[8*k +: 8];
                end
                if (!addr[31] && addr[29])
                begin
                    imem_m[a] = data[8*k +: 8];
                end
            end
        end
        if (addr[31:28] == 4'h8)
        begin
            tx_exp.push_back(data[7:0]);
        end
    endfunction

    function automatic logic [31:0] model_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] v;
        v = '0;
        if (!addr[31] && addr[28])
        begin
            for (int k = 0; k < 4; k++)
            begin
                if (int'(addr[1:0]) + k < 4)
                begin
                    v[8*k +: 8] = dmem_m[addr[11:0] + 12'(k)];
                end
            end
        end
        else if (addr[31:28] == 4'h8 && addr[2:0] == 3'h4)
        begin
            if (rx_exp.size() != 0)
            begin
                v = {24'h0, rx_exp.pop_front()};
            end
        end
        else if (addr[31:28] == 4'h8 && addr[2:0] == 3'h0)
        begin
            v = {30'h0, rx_exp.size() != 0, tx_exp.size() == 0};
        end
        return extend(f3, v);
    endfunction

    // Presents one request and returns one ns after the accepting edge
    task automatic issue(input logic [6:0] opc, input logic [2:0] f3,
                         input logic [31:0] addr, input logic [31:0] data);
        logic taken;
        taken        = 1'b0;
        stall_cycles = 0;
        req_valid    = 1'b1;
        req          = '{opcode: opc, funct3: f3, addr: addr, data: data};
        if (opc == mem_pkg::opc_store)
        begin
            model_store(f3, addr, data);
        end
        else if (opc == mem_pkg::opc_load)
        begin
            rsp_exp.push_back(model_load(f3, addr));
        end
        while (!taken)
        begin
            #1;
            taken = req_ready;
            @(posedge clk);
            #1;
            if (!taken)
            begin
                stall_cycles++;
            end
        end
        req_valid = 1'b0;
    endtask

    task automatic store_req(input logic [2:0] f3, input logic [31:0] addr,
                             input logic [31:0] data);
        issue(mem_pkg::opc_store, f3, addr, data);
    endtask

    task automatic load_req(input logic [2:0] f3, input logic [31:0] addr);
        issue(mem_pkg::opc_load, f3, addr, 32'h0);
    endtask

    task automatic fetch_check(input logic [9:0] idx);
        imem_addr = idx;
        @(posedge clk);
        #1;
        compare("imem_data", imem_data, {imem_m[{idx, 2'd3}], imem_m[{idx, 2'd2}],
                                         imem_m[{idx, 2'd1}], imem_m[{idx, 2'd0}]});
    endtask

    task automatic send_rx(input logic [7:0] b);
        logic taken;
        taken    = 1'b0;
        rx_valid = 1'b1;
        rx_data  = b;
        while (!taken)
        begin
            #1;
            taken = rx_ready;
            @(posedge clk);
            #1;
        end
        rx_valid = 1'b0;
        rx_exp.push_back(b);
    endtask

    task automatic wait_idle();
        while (rsp_exp.size() != 0 || tx_exp.size() != 0)
        begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report(input int num, input string name);
        wait_idle();
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 checks - checks_mark, errors - errors_mark);
        checks_mark = checks;
        errors_mark = errors;
    endtask

    // ------------------------------
    // Monitors
    // ------------------------------
    always @(posedge clk)
    begin
        #2;
        if (arst_n && rsp_valid)
        begin
            if (rsp_exp.size() == 0)
            begin
                errors++;
                $display("Load response arrived with no load outstanding");
            end
            else
            begin
                compare("rsp.data", rsp.data, rsp_exp.pop_front());
            end
        end
        if (arst_n && tx_valid && tx_ready)
        begin
            if (tx_exp.size() == 0)
            begin
                errors++;
                $display("Transmit byte appeared that was never stored");
            end
            else
            begin
                compare("tx_data", {24'h0, tx_data}, {24'h0, tx_exp.pop_front()});
            end
        end
    end

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial
    begin
        logic [9:0]  idx;
        logic [1:0]  off;
        logic [31:0] base;
        logic [2:0]  f3;

        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        imem_addr = '0;
        tx_ready  = 1'b1;
        rx_valid  = 1'b0;
        rx_data   = 8'h0;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < 24; i++)
        begin
            idx  = take_bits(10);
            base = dmem_base | {idx, 2'b00};
            dmem_words.push_back(idx);
            store_req(mem_pkg::fnc_w, base, take_bits(32));
            case (take_bits(2))
                2'd0:    f3 = mem_pkg::fnc_b;
                2'd1:    f3 = mem_pkg::fnc_h;
                default: f3 = mem_pkg::fnc_w;
            endcase
            off = take_bits(2);
            // Naturally aligned for the store size
            off = (f3 == mem_pkg::fnc_b) ? off : (f3 == mem_pkg::fnc_h) ? {off[1], 1'b0} : 2'b00;
            store_req(f3, base | off, take_bits(32));
            off = take_bits(2);
            load_req(mem_pkg::fnc_b, base | off);
            load_req(mem_pkg::fnc_bu, base | (off ^ 2'd1));
            off = take_bits(1) << 1;
            load_req(mem_pkg::fnc_h, base | off);
            load_req(mem_pkg::fnc_hu, base | (off ^ 2'd2));
            load_req(mem_pkg::fnc_w, base);
        end
        report(1, "byte/half/word stores and loads");

        for (int i = 0; i < 10; i++)
        begin
            idx  = take_bits(10);
            base = imem_base | {idx, 2'b00};
            imem_words.push_back(idx);
            store_req(mem_pkg::fnc_w, base, take_bits(32));
            store_req(mem_pkg::fnc_b, base | take_bits(2), take_bits(32));
            fetch_check(idx);
        end
        // Overlapping region, both memories take the word
        for (int i = 0; i < 6; i++)
        begin
            idx = take_bits(10);
            dmem_words.push_back(idx);
            imem_words.push_back(idx);
            store_req(mem_pkg::fnc_w, both_base | {idx, 2'b00}, take_bits(32));
            load_req(mem_pkg::fnc_w, both_base | {idx, 2'b00});
            fetch_check(idx);
        end
        report(2, "instruction fetch port");

        for (int i = 0; i < 32; i++)
        begin
            idx = dmem_words[take_bits(5) % dmem_words.size()];
            f3  = take_bits(1) ? mem_pkg::fnc_w : mem_pkg::fnc_bu;
            load_req(f3, dmem_base | {idx, 2'b00});
        end
        report(3, "back-to-back loads");

        tx_ready = 1'b0;
        store_req(mem_pkg::fnc_w, uart_stat, take_bits(32));
        fork
            store_req(mem_pkg::fnc_w, uart_stat, take_bits(32));
            begin
                repeat (3) @(posedge clk);
                #1;
                tx_ready = 1'b1;
            end
        join
        if (stall_cycles == 0)
        begin
            errors++;
            $display("Second transmit store was accepted while the buffer was full");
        end
        for (int i = 0; i < 4; i++)
        begin
            f3 = take_bits(1) ? mem_pkg::fnc_b : mem_pkg::fnc_w;
            store_req(f3, uart_stat, take_bits(32));
        end
        report(4, "uart transmit");

        for (int i = 0; i < 6; i++)
        begin
            send_rx(take_bits(8));
            load_req(mem_pkg::fnc_w, uart_stat);
            load_req(take_bits(1) ? mem_pkg::fnc_b : mem_pkg::fnc_bu, uart_rx);
            load_req(mem_pkg::fnc_w, uart_stat);
            load_req(mem_pkg::fnc_w, uart_rx);
        end
        report(5, "uart receive");

        for (int i = 0; i < 8; i++)
        begin
            idx = dmem_words[take_bits(5) % dmem_words.size()];
            store_req(mem_pkg::fnc_w, 32'h0000_0000 | {idx, 2'b00}, take_bits(32));
            store_req(mem_pkg::fnc_w, 32'h4000_0000 | {idx, 2'b00}, take_bits(32));
            store_req(mem_pkg::fnc_w, 32'h9000_0000 | {idx, 2'b00}, take_bits(32));
            issue(7'b011_0011, mem_pkg::fnc_w, both_base | {idx, 2'b00}, take_bits(32));
        end
        foreach (dmem_words[j])
        begin
            load_req(mem_pkg::fnc_w, dmem_base | {dmem_words[j], 2'b00});
        end
        foreach (imem_words[j])
        begin
            fetch_check(imem_words[j]);
        end
        report(6, "stores outside regions");

        assert_fails = dut_i.asserts_i.fail_count;
        $display("%0d checks, %0d errors, %0d assertion failures", checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0)
        begin
            $display("Regression passed");
        end
        else
        begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
